// File: build.f
+incdir+.
rgb_pwm_pkg.sv
debounce_onepulse.sv
load_fsm.sv
setting_bank.sv
pwm_core.sv
rgb_pwm_top.sv
rgb_pwm_assertions.sv
tb_rgb_pwm.sv

// File: debounce_onepulse.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module debounce_onepulse (
    input  logic clk_1k,
    input  logic rst_n,
    input  logic btn,
    output logic press
);

    localparam int CNT_W = $clog2(`RGB_PWM_DEBOUNCE_TICKS);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`RGB_PWM_DEBOUNCE_TICKS - 1);

    logic             sync_q1;
    logic             sync_q2;
    logic             stable_q;
    logic [CNT_W-1:0] cnt_q;
    logic             flip;

    // input differs long enough, take the new level
    assign flip = (sync_q2 != stable_q) && (cnt_q == CNT_LAST);

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1  <= 1'b0;
            sync_q2  <= 1'b0;
            stable_q <= 1'b0;
            cnt_q    <= '0;
            press    <= 1'b0;
        end else begin
            sync_q1 <= btn;    // async button
            sync_q2 <= sync_q1;
            press   <= flip && sync_q2;    // rising change only
            if (sync_q2 == stable_q || flip) begin
                cnt_q <= '0;    // any agreement restarts the run
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end
            if (flip) begin
                stable_q <= sync_q2;
            end
        end
    end

endmodule

`default_nettype wire

// File: load_fsm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module load_fsm (
    input  logic                   clk_1k,
    input  logic                   rst_n,
    input  logic                   press,
    output rgb_pwm_pkg::slot_wr_t  wr,
    output logic [3:0]             led
);

    rgb_pwm_pkg::slot_e slot_q;
    rgb_pwm_pkg::slot_e slot_nxt;

    // ------------------------------------------------------------
    // strobe and led decode
    // ------------------------------------------------------------
    always_comb begin
        wr       = '0;
        led      = 4'b0001;
        slot_nxt = rgb_pwm_pkg::SLOT_RES;
        case (slot_q)
            rgb_pwm_pkg::SLOT_RES: begin
                wr.res   = press;
                led      = 4'b0001;
                slot_nxt = rgb_pwm_pkg::SLOT_R;
            end
            rgb_pwm_pkg::SLOT_R: begin
                wr.r     = press;
                led      = 4'b0010;
                slot_nxt = rgb_pwm_pkg::SLOT_G;
            end
            rgb_pwm_pkg::SLOT_G: begin
                wr.g     = press;
                led      = 4'b0100;
                slot_nxt = rgb_pwm_pkg::SLOT_B;
            end
            default: begin
                wr.b     = press;
                led      = 4'b1000;
                slot_nxt = rgb_pwm_pkg::SLOT_RES;    // wrap to period slot
            end
        endcase
    end

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            slot_q <= rgb_pwm_pkg::SLOT_RES;
        end else if (press) begin
            slot_q <= slot_nxt;
        end
    end

endmodule

`default_nettype wire

// File: pwm_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module pwm_core (
    input  logic                   clk_1k,
    input  logic                   rst_n,
    input  rgb_pwm_pkg::pwm_cfg_t  cfg,
    output logic                   rgb_r,
    output logic                   rgb_g,
    output logic                   rgb_b
);

    localparam logic OFF_LVL = (`RGB_PWM_ACTIVE_LOW != 0) ? 1'b1 : 1'b0;

    logic [`RGB_PWM_W-1:0] cnt_q;
    rgb_pwm_pkg::pwm_cfg_t shadow_q;
    logic                  wrap;
    logic                  on_r;
    logic                  on_g;
    logic                  on_b;

    // ------------------------------------------------------------
    // period counter and shadow load
    // ------------------------------------------------------------
    assign wrap = (cnt_q == shadow_q.period);

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q           <= '0;
            shadow_q.period <= `RGB_PWM_RESET_PERIOD;
            shadow_q.duty   <= '0;
        end else if (wrap) begin
            cnt_q    <= '0;
            shadow_q <= cfg;    // new settings only between periods
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    // ------------------------------------------------------------
    // comparators and polarity stage
    // ------------------------------------------------------------
    assign on_r = (cnt_q < shadow_q.duty.r);    // duty 0 never on
    assign on_g = (cnt_q < shadow_q.duty.g);
    assign on_b = (cnt_q < shadow_q.duty.b);

    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            rgb_r <= OFF_LVL;
            rgb_g <= OFF_LVL;
            rgb_b <= OFF_LVL;
        end else begin
            rgb_r <= on_r ^ OFF_LVL;
            rgb_g <= on_g ^ OFF_LVL;
            rgb_b <= on_b ^ OFF_LVL;
        end
    end

endmodule

`default_nettype wire

// File: rgb_pwm_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module rgb_pwm_assertions #(
    parameter bit FSM_SIDE = 1'b1
) (
    input  logic                  clk_1k,
    input  logic                  rst_n,
    input  logic                  press,
    input  rgb_pwm_pkg::slot_wr_t wr,
    input  logic [3:0]            led,
    input  rgb_pwm_pkg::rgb_t     duty,
    input  logic                  rgb_r,
    input  logic                  rgb_g,
    input  logic                  rgb_b
);

    localparam logic OFF_LVL = (`RGB_PWM_ACTIVE_LOW != 0) ? 1'b1 : 1'b0;

    if (FSM_SIDE) begin : g_fsm
        // ------------------------------------------------------------
        // slot sequencer
        // ------------------------------------------------------------
        wr_onehot0: assert property (@(posedge clk_1k) disable iff (!rst_n) $onehot0(wr))
            else $error("more than one write strobe set");
        wr_needs_press: assert property (@(posedge clk_1k) disable iff (!rst_n)
            (wr != '0) |-> press)
            else $error("write strobe without press");
        led_onehot: assert property (@(posedge clk_1k) disable iff (!rst_n) $onehot(led))
            else $error("led not one-hot");
    end else begin : g_pwm
        // ------------------------------------------------------------
        // zero duty keeps the pin off
        // ------------------------------------------------------------
        r_off: assert property (@(posedge clk_1k) disable iff (!rst_n)
            (duty.r == '0) |=> (rgb_r == OFF_LVL))
            else $error("red pin on with zero duty");
        g_off: assert property (@(posedge clk_1k) disable iff (!rst_n)
            (duty.g == '0) |=> (rgb_g == OFF_LVL))
            else $error("green pin on with zero duty");
        b_off: assert property (@(posedge clk_1k) disable iff (!rst_n)
            (duty.b == '0) |=> (rgb_b == OFF_LVL))
            else $error("blue pin on with zero duty");
    end

endmodule

// each instance checks only the block it sits in
bind load_fsm rgb_pwm_assertions #(.FSM_SIDE(1'b1)) u_fsm_chk (
    .clk_1k (clk_1k),
    .rst_n  (rst_n),
    .press  (press),
    .wr     (wr),
    .led    (led),
    .duty   (24'hff_ffff),
    .rgb_r  (1'b1),
    .rgb_g  (1'b1),
    .rgb_b  (1'b1)
);

bind pwm_core rgb_pwm_assertions #(.FSM_SIDE(1'b0)) u_pwm_chk (
    .clk_1k (clk_1k),
    .rst_n  (rst_n),
    .press  (1'b0),
    .wr     (4'b0000),
    .led    (4'b0001),
    .duty   (shadow_q.duty),
    .rgb_r  (rgb_r),
    .rgb_g  (rgb_g),
    .rgb_b  (rgb_b)
);

`default_nettype wire

// File: rgb_pwm_defines.svh
`ifndef RGB_PWM_DEFINES_SVH
`define RGB_PWM_DEFINES_SVH

// ------------------------------------------------------------
// button filter
// ------------------------------------------------------------
`define RGB_PWM_DEBOUNCE_TICKS 20    // stable cycles before level flips

// ------------------------------------------------------------
// settings and outputs
// ------------------------------------------------------------
`define RGB_PWM_W 8                  // switch and setting width
`define RGB_PWM_RESET_PERIOD 8'd63   // period slot after reset
`define RGB_PWM_ACTIVE_LOW 1         // 1: led pin low while channel on

`endif

// File: rgb_pwm_pkg.sv
`default_nettype none

`include "rgb_pwm_defines.svh"

package rgb_pwm_pkg;

    // slot order matches the button sequence
    typedef enum logic [1:0] {
        SLOT_RES = 2'd0,
        SLOT_R   = 2'd1,
        SLOT_G   = 2'd2,
        SLOT_B   = 2'd3
    } slot_e;

    typedef struct packed {
        logic res;    // period slot
        logic r;
        logic g;
        logic b;
    } slot_wr_t;

    typedef struct packed {
        logic [`RGB_PWM_W-1:0] r;
        logic [`RGB_PWM_W-1:0] g;
        logic [`RGB_PWM_W-1:0] b;
    } rgb_t;

    typedef struct packed {
        logic [`RGB_PWM_W-1:0] period;    // counter top, period+1 cycles
        rgb_t                  duty;
    } pwm_cfg_t;

endpackage

`default_nettype wire

// File: rgb_pwm_top.sv
`timescale 1ns/1ps
`default_nettype none

module rgb_pwm_top (
    input  logic       clk_1k,
    input  logic       rst_n,
    input  logic       btn,
    input  logic [7:0] sw,
    output logic [3:0] led,
    output logic       rgb_r,
    output logic       rgb_g,
    output logic       rgb_b
);

    logic                  press;
    rgb_pwm_pkg::slot_wr_t wr;
    rgb_pwm_pkg::pwm_cfg_t cfg;

    debounce_onepulse u_db (
        .clk_1k (clk_1k),
        .rst_n  (rst_n),
        .btn    (btn),
        .press  (press)
    );

    load_fsm u_fsm (
        .clk_1k (clk_1k),
        .rst_n  (rst_n),
        .press  (press),
        .wr     (wr),
        .led    (led)
    );

    setting_bank u_bank (
        .clk_1k (clk_1k),
        .rst_n  (rst_n),
        .wr     (wr),
        .sw     (sw),
        .cfg    (cfg)
    );

    pwm_core u_pwm (
        .clk_1k (clk_1k),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .rgb_r  (rgb_r),
        .rgb_g  (rgb_g),
        .rgb_b  (rgb_b)
    );

endmodule

`default_nettype wire

// File: rgb_pwm_vectors.txt
// op_sw_len_expr_expg_expb, hex: op 01 press (len = hold cycles),
// 02 led check (sw = pattern), 03 measure (len = periods, exp = low cycles)
03_00_001_000_000_000  // reset window, all pins off
02_01_000_000_000_000
01_55_00A_000_000_000  // bounce, rejected
02_01_000_000_000_000
01_63_028_000_000_000  // period 99
02_02_000_000_000_000
01_19_028_000_000_000  // red 25
02_04_000_000_000_000
01_32_028_000_000_000  // green 50
02_08_000_000_000_000
01_4B_028_000_000_000  // blue 75
02_01_000_000_000_000
03_00_003_04B_096_0E1
01_63_028_000_000_000
02_02_000_000_000_000
01_00_028_000_000_000  // red off
02_04_000_000_000_000
01_FF_028_000_000_000  // green always on
02_08_000_000_000_000
01_4B_028_000_000_000
02_01_000_000_000_000
03_00_002_000_0C8_096
01_31_028_000_000_000  // period 49, duties kept
02_02_000_000_000_000
03_00_002_000_064_064
01_19_028_000_000_000
01_32_028_000_000_000
01_4B_028_000_000_000
02_01_000_000_000_000
03_00_002_032_064_064

// File: run_sim.sh
#!/bin/sh
# compile and run the RGB PWM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rgb_pwm -f build.f
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rgb_pwm)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
exit 1

// File: setting_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module setting_bank (
    input  logic                   clk_1k,
    input  logic                   rst_n,
    input  rgb_pwm_pkg::slot_wr_t  wr,
    input  logic [`RGB_PWM_W-1:0]  sw,
    output rgb_pwm_pkg::pwm_cfg_t  cfg
);

    // one register per slot, loaded from the switches
    always_ff @(posedge clk_1k or negedge rst_n) begin
        if (!rst_n) begin
            cfg.period <= `RGB_PWM_RESET_PERIOD;
            cfg.duty.r <= '0;
            cfg.duty.g <= '0;
            cfg.duty.b <= '0;
        end else begin
            if (wr.res) begin
                cfg.period <= sw;
            end
            if (wr.r) begin
                cfg.duty.r <= sw;
            end
            if (wr.g) begin
                cfg.duty.g <= sw;
            end
            if (wr.b) begin
                cfg.duty.b <= sw;
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_rgb_pwm.sv
`timescale 1ns/1ps
`default_nettype none

`include "rgb_pwm_defines.svh"

module tb_rgb_pwm;

    logic       clk_1k;
    logic       rst_n;
    logic       btn;
    logic [7:0] sw;
    wire  [3:0] led;
    wire        rgb_r;
    wire        rgb_g;
    wire        rgb_b;

    logic [63:0] vec [0:63];    // op, sw, len, exp r, exp g, exp b
    int errors = 0;
    int tests = 0;
    int cycles = 0;
    int limit = 0;
    int slot = 0;
    int setting [4];            // period, r, g, b as the model sees them

    rgb_pwm_top i_rgb_pwm_top (
        .clk_1k (clk_1k),
        .rst_n  (rst_n),
        .btn    (btn),
        .sw     (sw),
        .led    (led),
        .rgb_r  (rgb_r),
        .rgb_g  (rgb_g),
        .rgb_b  (rgb_b)
    );

    initial clk_1k = 1'b0;
    always #2 clk_1k = ~clk_1k;

    always @(posedge clk_1k) begin
        cycles <= cycles + 1;
        if (limit != 0 && cycles >= limit) begin
            $display("timeout after %0d cycles, the vector run did not finish", cycles);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input int exp, input int act);
        if (exp !== act) begin
            $display("MISMATCH time=%0t %s expected=%0d actual=%0d", $time, name, exp, act);
            errors++;
        end
    endtask

    function automatic int on_count(input int duty, input int period, input int n);
        on_count = n * ((duty < period + 1) ? duty : period + 1);
    endfunction

    // ------------------------------------------------------------
    // operations
    // ------------------------------------------------------------
    task automatic push_button(input int value, input int hold);
        @(posedge clk_1k);
        sw  <= value[7:0];
        btn <= 1'b1;
        repeat (hold) @(posedge clk_1k);
        btn <= 1'b0;
        repeat (30) @(posedge clk_1k);    // release debounce settles
        if (hold >= 40) begin
            setting[slot] = value;
            slot = (slot + 1) % 4;
        end else if (hold >= `RGB_PWM_DEBOUNCE_TICKS) begin
            $display("vector file has a hold of %0d cycles, neither bounce nor press", hold);
            errors++;
        end
        $display("test %0d press sw=%0d hold=%0d done", tests, value, hold);
    endtask

    task automatic check_led(input int exp_file);
        int exp;
        exp = 1 << slot;
        if (exp_file != exp) begin
            $display("vector file led value %0d disagrees with the slot model", exp_file);
            errors++;
        end
        @(negedge clk_1k);
        check_value("led", exp, int'(led));
        $display("test %0d led check done", tests);
    endtask

    task automatic measure(input int n, input int fr, input int fg, input int fb);
        int p;
        int er;
        int eg;
        int eb;
        int cr;
        int cg;
        int cb;
        p  = setting[0];
        er = on_count(setting[1], p, n);
        eg = on_count(setting[2], p, n);
        eb = on_count(setting[3], p, n);
        cr = 0;
        cg = 0;
        cb = 0;
        if (er != fr || eg != fg || eb != fb) begin
            $display("vector file on-counts disagree with the settings model");
            errors++;
        end
        repeat (300) @(posedge clk_1k);    // new settings reach the shadow
        repeat (n * (p + 1)) begin
            @(negedge clk_1k);
            if (!rgb_r) cr++;    // active low
            if (!rgb_g) cg++;
            if (!rgb_b) cb++;
        end
        check_value("rgb_r", er, cr);
        check_value("rgb_g", eg, cg);
        check_value("rgb_b", eb, cb);
        $display("test %0d measure %0d periods of %0d done", tests, n, p + 1);
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int i;
        int budget;
        btn = 1'b0;
        sw  = 8'd0;
        rst_n = 1'b0;
        setting[0] = 63;
        setting[1] = 0;
        setting[2] = 0;
        setting[3] = 0;
        for (i = 0; i < 64; i++) begin
            vec[i] = 64'd0;
        end
        $readmemh("rgb_pwm_vectors.txt", vec);
        budget = 8;
        for (i = 0; i < 64 && vec[i][63:56] != 8'h00; i++) begin
            if (vec[i][63:56] == 8'h01) budget += int'(vec[i][47:36]) + 60;
            else if (vec[i][63:56] == 8'h03) budget += (int'(vec[i][47:36]) + 2) * 256;
            else budget += 4;
        end
        limit = 2 * budget;
        repeat (4) @(posedge clk_1k);
        rst_n <= 1'b1;
        for (i = 0; i < 64 && vec[i][63:56] != 8'h00; i++) begin
            case (vec[i][63:56])
                8'h01: push_button(int'(vec[i][55:48]), int'(vec[i][47:36]));
                8'h02: check_led(int'(vec[i][55:48]));
                8'h03: measure(int'(vec[i][47:36]), int'(vec[i][35:24]),
                               int'(vec[i][23:12]), int'(vec[i][11:0]));
                default: begin
                    $display("unknown operation code in vector line %0d", i);
                    errors++;
                end
            endcase
            tests++;
        end
        $display("tests %0d errors %0d", tests, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
